//--- sources.f
+incdir+hw
hw/dcache_pkg.sv
hw/line_memory.sv
hw/store_buffer.sv
hw/dcache.sv
hw/dcache_subsystem.sv
sim/dcache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dcache_tb \
    -f sources.f --Mdir obj_dir -o dcache_tb_sim

./obj_dir/dcache_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "Run failed, see sim.log"
exit 1

//--- sim/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_tb;

    // About 200 accesses at a worst case of 20 cycles each
    localparam int MAX_CYCLES = 4000;
    localparam int MEM_BYTES  = `MEM_LINES * `LINE_SIZE / 8;

    logic clk;
    logic rst;
    dcache_pkg::core_access_t access;
    logic                  hit;
    logic [`WORD_SIZE-1:0] read_data;
    logic                  stall;
    logic                  sb_empty;

    // Reference memory, bytes written by accepted stores
    logic [7:0] ref_mem [logic [31:0]];
    int errors;
    int checks;
    int cycles;
    int seed;

    dcache_subsystem dut0 (
        .clk       (clk),
        .rst       (rst),
        .access    (access),
        .hit       (hit),
        .read_data (read_data),
        .stall     (stall),
        .sb_empty  (sb_empty)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        logic [31:0] init_word;
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        // Untouched words hold their own byte address, wrapped to the model size
        init_word = {addr[31:2], 2'b00} % MEM_BYTES;
        return init_word[8*addr[1:0] +: 8];
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input logic is_byte);
        logic [7:0]  b;
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        b    = ref_byte(addr);
        // Byte loads sign extend, words are little endian
        if (is_byte) begin
            return {{24{b[7]}}, b};
        end
        return {ref_byte(base + 3), ref_byte(base + 2), ref_byte(base + 1), ref_byte(base)};
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic is_byte,
                                      input logic [31:0] value);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (is_byte) begin
            ref_mem[addr] = value[7:0];
        end else begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[base + 32'(i)] = value[8*i +: 8];
            end
        end
    endfunction

    // Repeat a load until it hits, then compare with the reference
    task automatic load_and_check(input logic [31:0] addr, input logic is_byte,
                                  output int attempts);
        logic [31:0] expected;
        int n;
        n = 0;
        access.valid = 1'b1;
        access.store = 1'b0;
        access.addr  = addr;
        access.size  = is_byte ? dcache_pkg::BYTE_ACCESS : dcache_pkg::WORD_ACCESS;
        @(negedge clk);
        while (!hit && n < 20) begin
            n++;
            @(negedge clk);
        end
        expected = expected_load(addr, is_byte);
        checks++;
        assert (hit) else begin
            $display("Load from %h got no hit within 20 cycles", addr);
            errors++;
        end
        if (hit) begin
            assert (read_data == expected) else begin
                $display("FAILED at %0t: load %h returned %h, expected %h",
                         $time, addr, read_data, expected);
                errors++;
            end
        end
        attempts = n;
        @(posedge clk);
        #5;
        access.valid = 1'b0;
    endtask

    // Hold a store until stall drops, counting stalled cycles
    task automatic store_access(input logic [31:0] addr, input logic is_byte,
                                input logic [31:0] value, output int stalled);
        int n;
        n = 0;
        access.valid       = 1'b1;
        access.store       = 1'b1;
        access.addr        = addr;
        access.size        = is_byte ? dcache_pkg::BYTE_ACCESS : dcache_pkg::WORD_ACCESS;
        access.store_value = value;
        @(negedge clk);
        while (stall && n < 40) begin
            n++;
            @(negedge clk);
        end
        assert (!stall) else begin
            $display("Store to %h was still stalled after 40 cycles", addr);
            errors++;
        end
        if (!stall) begin
            ref_write(addr, is_byte, value);
        end
        stalled = n;
        @(posedge clk);
        #5;
        access.valid = 1'b0;
        access.store = 1'b0;
    endtask

    task automatic drain_stores;
        int n;
        n = 0;
        @(negedge clk);
        while (!sb_empty && n < 40) begin
            n++;
            @(negedge clk);
        end
        assert (sb_empty) else begin
            $display("Store buffer did not drain within 40 cycles");
            errors++;
        end
        @(posedge clk);
        #5;
    endtask

    // One load attempt that only starts a miss
    task automatic issue_miss(input logic [31:0] addr);
        access.valid = 1'b1;
        access.store = 1'b0;
        access.addr  = addr;
        access.size  = dcache_pkg::WORD_ACCESS;
        @(posedge clk);
        #5;
        access.valid = 1'b0;
    endtask

    task automatic check_reset_state;
        int n;
        checks += 2;
        assert (!stall && sb_empty) else begin
            $display("FAILED at %0t: after reset stall=%b sb_empty=%b", $time, stall, sb_empty);
            errors++;
        end
        load_and_check(32'h040, 1'b0, n);
        // Refill lands at the end of cycle MEM_LATENCY
        assert (n == `MEM_LATENCY + 1) else begin
            $display("FAILED at %0t: first load hit after %0d cycles", $time, n);
            errors++;
        end
    endtask

    task automatic load_widths;
        int n;
        load_and_check(32'h18c, 1'b1, n);
        load_and_check(32'h180, 1'b1, n);
        load_and_check(32'h181, 1'b1, n);
        load_and_check(32'h188, 1'b0, n);
        load_and_check(32'h044, 1'b0, n);
    endtask

    task automatic store_then_load;
        int n;
        store_access(32'h048, 1'b0, 32'hdeadbeef, n);
        drain_stores();
        load_and_check(32'h048, 1'b0, n);
        // Other bytes of the word must survive
        store_access(32'h04d, 1'b1, 32'h000000a5, n);
        drain_stores();
        load_and_check(32'h04c, 1'b0, n);
        // Line not resident, store joins the miss
        store_access(32'h250, 1'b0, 32'h12345678, n);
        drain_stores();
        load_and_check(32'h250, 1'b0, n);
    endtask

    task automatic dirty_eviction;
        int n;
        store_access(32'h098, 1'b0, 32'hcafef00d, n);
        drain_stores();
        // Same set, other tag, pushes the dirty line out
        load_and_check(32'h190, 1'b0, n);
        load_and_check(32'h098, 1'b0, n);
    endtask

    task automatic back_pressure;
        int n;
        int first_four;
        issue_miss(32'h2a0);
        store_access(32'h1a0, 1'b0, 32'h0badcafe, n);
        checks++;
        // Stalled from the cycle after the request until the refill edge
        assert (n == `MEM_LATENCY) else begin
            $display("FAILED at %0t: store behind a miss stalled %0d cycles", $time, n);
            errors++;
        end
        drain_stores();
        load_and_check(32'h1a0, 1'b0, n);
        first_four = 0;
        for (int i = 0; i < 4; i++) begin
            store_access(32'h2e0 + 32'(4 * i), 1'b0, 32'h5a5a0000 + 32'(i), n);
            first_four += n;
        end
        store_access(32'h2e1, 1'b1, 32'h000000c3, n);
        checks++;
        assert (first_four == 0 && n > 0) else begin
            $display("FAILED at %0t: stall counts %0d then %0d", $time, first_four, n);
            errors++;
        end
        drain_stores();
        for (int i = 0; i < 4; i++) begin
            load_and_check(32'h2e0 + 32'(4 * i), 1'b0, n);
        end
        load_and_check(32'h1a0, 1'b0, n);
    endtask

    task automatic random_mix;
        logic [31:0] line_base [8];
        logic [31:0] addr;
        logic [31:0] value;
        int r;
        int n;
        line_base = '{32'h040, 32'h050, 32'h060, 32'h070,
                      32'h300, 32'h310, 32'h320, 32'h330};
        for (int i = 0; i < 150; i++) begin
            r    = $random(seed);
            addr = line_base[r[2:0]] | {26'b0, r[4:3], 4'b0000} >> 2;
            if (r[8]) begin
                addr = addr | {30'b0, r[6:5]};
            end
            if (r[7]) begin
                value = $random(seed);
                store_access(addr, r[8], value, n);
            end else begin
                drain_stores();
                load_and_check(addr, r[8], n);
            end
        end
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        access = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed   = 16;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        check_reset_state();
        load_widths();
        store_then_load();
        dirty_eviction();
        back_pressure();
        random_mix();
        drain_stores();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- hw/dcache_subsystem.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_subsystem (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::core_access_t access,
    output logic                     hit,
    output logic [`WORD_SIZE-1:0]    read_data,
    output logic                     stall,
    output logic                     sb_empty
);

    dcache_pkg::core_access_t cache_access;
    dcache_pkg::sb_entry_t    push_entry;
    dcache_pkg::sb_entry_t    sb_head;
    dcache_pkg::line_req_t    mem_req;
    dcache_pkg::line_resp_t   mem_resp;
    dcache_pkg::line_wb_t     mem_wb;

    logic sb_head_valid;
    logic sb_full;
    logic store_stall;
    logic store_success;
    logic push;

    // Store hidden from the cache while the buffer has no room, so it pins nothing
    assign cache_access = '{valid:       access.valid && !(access.store && sb_full),
                            addr:        access.addr,
                            size:        access.size,
                            store:       access.store,
                            store_value: access.store_value};

    assign stall      = store_stall || sb_full;
    assign push       = access.valid && access.store && !stall;
    assign push_entry = '{addr: access.addr, value: access.store_value, size: access.size};

    dcache u_dcache (
        .clk           (clk),
        .rst           (rst),
        .access        (cache_access),
        .sb_head       (sb_head),
        .wenable       (sb_head_valid),
        .mem_resp      (mem_resp),
        .hit           (hit),
        .store_stall   (store_stall),
        .read_data     (read_data),
        .store_success (store_success),
        .mem_req       (mem_req),
        .mem_wb        (mem_wb)
    );

    store_buffer u_store_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (store_success),
        .head       (sb_head),
        .head_valid (sb_head_valid),
        .full       (sb_full),
        .empty      (sb_empty)
    );

    line_memory u_line_memory (
        .clk  (clk),
        .rst  (rst),
        .req  (mem_req),
        .wb   (mem_wb),
        .resp (mem_resp)
    );

endmodule

//--- hw/dcache.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::core_access_t access,
    input  dcache_pkg::sb_entry_t    sb_head,
    input  logic                     wenable,
    input  dcache_pkg::line_resp_t   mem_resp,
    output logic                     hit,
    output logic                     store_stall,
    output logic [`WORD_SIZE-1:0]    read_data,
    output logic                     store_success,
    output dcache_pkg::line_req_t    mem_req,
    output dcache_pkg::line_wb_t     mem_wb
);

    // Direct mapped with one way per set
    localparam int N_SETS = `CACHE_N_LINES / `CACHE_ASSOCIATIVITY;
    // Enough to count every store buffer entry
    localparam int PIN_W = $clog2(`STORE_BUFFER_ENTRIES) + 1;

    // Resident line state
    logic [`TAG_SIZE-1:0]  tags    [N_SETS];
    logic [`LINE_SIZE-1:0] data_q  [N_SETS];
    logic [N_SETS-1:0]     dirty;
    logic [PIN_W-1:0]      pin_cnt [N_SETS];

    // Outstanding miss per set
    logic [N_SETS-1:0]     mr_present;
    logic [`TAG_SIZE-1:0]  mr_tag [N_SETS];
    logic [PIN_W-1:0]      mr_pin [N_SETS];

    // Core access split
    logic [`OFFSET_SIZE-1:0] offset;
    logic [`SET_SIZE-1:0]    set;
    logic [`TAG_SIZE-1:0]    tag;
    assign offset = access.addr[`OFFSET_SIZE-1:0];
    assign set    = access.addr[`OFFSET_SIZE +: `SET_SIZE];
    assign tag    = access.addr[`WORD_SIZE-1 -: `TAG_SIZE];

    // Store buffer head split
    logic [`OFFSET_SIZE-1:0] sb_offset;
    logic [`SET_SIZE-1:0]    sb_set;
    logic [`TAG_SIZE-1:0]    sb_tag;
    assign sb_offset = sb_head.addr[`OFFSET_SIZE-1:0];
    assign sb_set    = sb_head.addr[`OFFSET_SIZE +: `SET_SIZE];
    assign sb_tag    = sb_head.addr[`WORD_SIZE-1 -: `TAG_SIZE];

    // Refill split
    logic [`SET_SIZE-1:0] resp_set;
    logic [`TAG_SIZE-1:0] resp_tag;
    assign resp_set = mem_resp.addr[`OFFSET_SIZE +: `SET_SIZE];
    assign resp_tag = mem_resp.addr[`WORD_SIZE-1 -: `TAG_SIZE];

    logic tag_hit;
    logic is_store;
    logic pin_inc;
    logic mr_merge;
    logic refill_merge;

    assign tag_hit  = tags[set] == tag;
    assign is_store = access.valid && access.store;
    assign hit      = access.valid && tag_hit;

    // Stores wait behind a pending miss for another tag or a pinned victim
    assign store_stall = is_store && (mr_present[set] ? (mr_tag[set] != tag)
                                                      : (!tag_hit && pin_cnt[set] != '0));

    // Store hits the resident line and no refill is pending in that set
    assign pin_inc  = is_store && tag_hit && !mr_present[set];
    // Store rides along with the miss already in flight
    assign mr_merge = is_store && mr_present[set] && (mr_tag[set] == tag);
    // Merge in the very cycle the line arrives
    assign refill_merge = mr_merge && mem_resp.valid && (resp_set == set);

    // Head of the store buffer retires once its line is resident
    assign store_success = wenable && (tags[sb_set] == sb_tag);

    // Load data with byte sign extension
    logic [`LINE_SIZE-1:0] line_rd;
    logic [7:0]            byte_rd;
    logic [`WORD_SIZE-1:0] word_rd;
    assign line_rd = data_q[set];
    assign byte_rd = line_rd[{offset, 3'b000} +: 8];
    assign word_rd = line_rd[{offset[`OFFSET_SIZE-1:2], 5'b00000} +: `WORD_SIZE];
    assign read_data = (access.size == dcache_pkg::BYTE_ACCESS)
                     ? {{(`WORD_SIZE-8){byte_rd[7]}}, byte_rd} : word_rd;

    always_comb begin
        // One miss per set and never while the victim is still pinned
        mem_req.valid = access.valid && !tag_hit && !mr_present[set] && (pin_cnt[set] == '0);
        mem_req.addr  = {tag, set, {`OFFSET_SIZE{1'b0}}};

        // Old line goes out on the refill edge when dirty
        mem_wb.valid = mem_resp.valid && dirty[resp_set];
        mem_wb.addr  = {tags[resp_set], resp_set, {`OFFSET_SIZE{1'b0}}};
        mem_wb.data  = data_q[resp_set];
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            dirty      <= '0;
            mr_present <= '0;
            for (int i = 0; i < N_SETS; i++) begin
                tags[i]    <= '0;
                pin_cnt[i] <= '0;
                mr_tag[i]  <= '0;
                mr_pin[i]  <= '0;
            end
        end else begin
            if (store_success) begin
                dirty[sb_set] <= 1'b1;
            end

            // Same set inc and dec cancel
            if (pin_inc && !(store_success && sb_set == set)) begin
                pin_cnt[set] <= pin_cnt[set] + 1'b1;
            end
            if (store_success && !(pin_inc && sb_set == set)) begin
                pin_cnt[sb_set] <= pin_cnt[sb_set] - 1'b1;
            end

            // New miss record where a store pins the incoming line once
            if (mem_req.valid) begin
                mr_present[set] <= 1'b1;
                mr_tag[set]     <= tag;
                mr_pin[set]     <= is_store ? PIN_W'(1) : '0;
            end
            if (mr_merge) begin
                mr_pin[set] <= mr_pin[set] + 1'b1;
            end

            // Install refill and hand over the pending pins
            if (mem_resp.valid) begin
                tags[resp_set]       <= resp_tag;
                dirty[resp_set]      <= 1'b0;
                pin_cnt[resp_set]    <= mr_pin[resp_set] + PIN_W'(refill_merge);
                mr_present[resp_set] <= 1'b0;
                mr_pin[resp_set]     <= '0;
            end
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        if (mem_resp.valid) begin
            data_q[resp_set] <= mem_resp.data;
        end
        if (store_success) begin
            if (sb_head.size == dcache_pkg::BYTE_ACCESS) begin
                data_q[sb_set][{sb_offset, 3'b000} +: 8] <= sb_head.value[7:0];
            end else begin
                data_q[sb_set][{sb_offset[`OFFSET_SIZE-1:2], 5'b00000} +: `WORD_SIZE]
                    <= sb_head.value;
            end
        end
    end

    // Evicting a line with stores still queued would lose them
    a_wb_unpinned: assert property (@(posedge clk) disable iff (rst)
        mem_wb.valid |-> pin_cnt[resp_set] == '0);

    // A retired store always finds its line pinned
    a_store_pinned: assert property (@(posedge clk) disable iff (rst)
        store_success |-> pin_cnt[sb_set] != '0);

    // Memory only answers requests we recorded
    a_resp_expected: assert property (@(posedge clk) disable iff (rst)
        mem_resp.valid |-> mr_present[resp_set] && (mr_tag[resp_set] == resp_tag));

endmodule

//--- hw/store_buffer.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module store_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  dcache_pkg::sb_entry_t push_entry,
    input  logic                  pop,
    output dcache_pkg::sb_entry_t head,
    output logic                  head_valid,
    output logic                  full,
    output logic                  empty
);

    localparam int DEPTH = `STORE_BUFFER_ENTRIES;
    localparam int PTR_W = $clog2(DEPTH);

    // Entry storage
    dcache_pkg::sb_entry_t entries [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    // One extra bit so DEPTH fits
    logic [PTR_W:0]   count;

    // Oldest store is always at the read pointer
    assign head       = entries[rd_ptr];
    assign empty      = count == '0;
    assign full       = count == (PTR_W + 1)'(DEPTH);
    assign head_valid = !empty;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // Core side must honour full
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

    // Cache only retires a store that is actually presented
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid);

endmodule

//--- hw/line_memory.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module line_memory (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::line_req_t  req,
    input  dcache_pkg::line_wb_t   wb,
    output dcache_pkg::line_resp_t resp
);

    localparam int IDX_W     = $clog2(`MEM_LINES);
    localparam int WORDS     = `LINE_SIZE / `WORD_SIZE;
    localparam int LINE_BYTES = `LINE_SIZE / 8;

    logic [`LINE_SIZE-1:0] mem [`MEM_LINES];

    // Line index wraps modulo MEM_LINES
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] wb_idx;
    assign req_idx = req.addr[`OFFSET_SIZE +: IDX_W];
    assign wb_idx  = wb.addr[`OFFSET_SIZE +: IDX_W];

    // Every word starts out holding its own byte address
    initial begin
        for (int l = 0; l < `MEM_LINES; l++) begin
            for (int w = 0; w < WORDS; w++) begin
                mem[l][w*`WORD_SIZE +: `WORD_SIZE] = `WORD_SIZE'(l * LINE_BYTES + w * 4);
            end
        end
    end

    // Write-back lands at the edge it is presented
    always @(posedge clk) begin
        if (wb.valid) begin
            mem[wb_idx] <= wb.data;
        end
    end

    // Response pipeline, last stage drives resp
    dcache_pkg::line_resp_t pipe [`MEM_LATENCY];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LATENCY; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= req.valid;
            pipe[0].addr  <= req.addr;
            // Same-edge write-back to this line wins over stale contents
            pipe[0].data  <= (wb.valid && wb_idx == req_idx) ? wb.data : mem[req_idx];
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign resp = pipe[`MEM_LATENCY-1];

endmodule

//--- hw/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    // Access width for loads and stores
    typedef enum logic {
        BYTE_ACCESS = 1'b0,
        WORD_ACCESS = 1'b1
    } access_size_t;

    // One access from the core
    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] addr;
        access_size_t          size;
        logic                  store;
        logic [`WORD_SIZE-1:0] store_value;
    } core_access_t;

    // Store waiting to retire into the cache
    typedef struct packed {
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] value;
        access_size_t          size;
    } sb_entry_t;

    // Line fetch request, addr is line aligned
    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] addr;
    } line_req_t;

    // Line returned by memory
    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] addr;
        logic [`LINE_SIZE-1:0] data;
    } line_resp_t;

    // Dirty line going back to memory
    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] addr;
        logic [`LINE_SIZE-1:0] data;
    } line_wb_t;

endpackage

//--- hw/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Word and line widths in bits
`define WORD_SIZE 32
`define LINE_SIZE 128

// Cache geometry
`define CACHE_N_LINES 4
// Kept for a set-associative variant, one way for now
`define CACHE_ASSOCIATIVITY 1

// Address split, tag takes the remaining upper bits
`define OFFSET_SIZE 4
`define SET_SIZE 2
`define TAG_SIZE 26

// Store buffer depth
`define STORE_BUFFER_ENTRIES 4

// Backing memory model
`define MEM_LATENCY 5
// Lines held, addresses wrap modulo this count
`define MEM_LINES 64

`endif
